/* design/frame_pkg.sv */
package frame_pkg;

    // Colour widths per channel
    localparam int colour_in_w  = 4;    // Game side
    localparam int colour_out_w = 6;    // VGA side
    localparam int num_chan     = 3;    // R, G, B

    // Game joystick: 4 directions and 6 buttons
    localparam int joy_w = 10;

    // Controller word from the board, all bits active high
    localparam int ctrl_w      = 16;
    localparam int coin_bit    = 10;
    localparam int start_bit   = 11;
    localparam int pause_bit   = 12;
    localparam int service_bit = 13;

    // Audio sample width
    localparam int snd_w = 16;

    // Reset stretch in clk_sys cycles
    localparam int rst_stretch = 16;
    localparam int rst_cnt_w   = $clog2(rst_stretch + 1);

endpackage

/* design/board_reset.sv */
`timescale 1ns/10ps

module board_reset import frame_pkg::*; (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic downloading,
    input  logic dip_flip,
    input  logic rst_req,
    output logic rst,
    output logic game_rst
);

logic [rst_cnt_w-1:0] rst_cnt;      // Board reset stretch
logic [rst_cnt_w-1:0] game_cnt;     // Game reset stretch
logic                 dip_last;
logic                 dl_last;
logic                 rst_busy;
logic                 game_evt;

assign rst_busy = rst_cnt != '0;

// Any DIP flip change, reset request or end of ROM download
assign game_evt = (dip_flip != dip_last) || rst_req || (dl_last && !downloading);

always_ff @(posedge clk_sys) begin
    dip_last <= dip_flip;
    dl_last  <= downloading;
end

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        rst_cnt  <= rst_cnt_w'(rst_stretch);
        game_cnt <= '0;
        rst      <= 1'b1;
        game_rst <= 1'b1;
    end else begin
        if (rst_busy) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
        if (game_evt) begin
            game_cnt <= rst_cnt_w'(rst_stretch - 1);    // This edge counts as the first
        end else if (game_cnt != '0) begin
            game_cnt <= game_cnt - 1'b1;
        end
        rst      <= rst_busy;
        game_rst <= rst_busy || downloading || game_evt || game_cnt != '0;
    end
end

// The game never runs while the board is held in reset
a_game_in_rst: assert property (@(posedge clk_sys) rst |-> game_rst)
    else $error("game_rst low while rst is high");

endmodule

/* design/joystick_map.sv */
`timescale 1ns/10ps

module joystick_map import frame_pkg::*; #(
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
) (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic              game_rst,
    input  logic [ctrl_w-1:0] joystick1,
    input  logic [ctrl_w-1:0] joystick2,
    output logic [joy_w-1:0]  game_joystick1,
    output logic [joy_w-1:0]  game_joystick2,
    output logic [1:0]        game_coin,
    output logic [1:0]        game_start,
    output logic              game_service,
    output logic              game_pause
);

localparam logic inv = !GAME_INPUTS_ACTIVE_HIGH;   // Invert for active-low games

logic [1:0] pause_now;
logic [1:0] pause_last;
logic       pause_edge;

// Mask unused buttons, then apply game polarity
function automatic logic [joy_w-1:0] map_joy(input logic [ctrl_w-1:0] word);
    logic [joy_w-1:0] bits;
    bits = word[joy_w-1:0];
    if (THREE_BUTTONS) begin
        bits[joy_w-1 -: 3] = '0;    // Buttons 4 to 6
    end
    return bits ^ {joy_w{inv}};
endfunction

assign pause_now  = {joystick2[pause_bit], joystick1[pause_bit]};
assign pause_edge = |(pause_now & ~pause_last);

always_ff @(posedge clk_sys) begin
    pause_last <= pause_now;
end

always_ff @(posedge clk_sys) begin
    if (!rst_n || game_rst) begin
        game_joystick1 <= {joy_w{inv}};
        game_joystick2 <= {joy_w{inv}};
        game_coin      <= {2{inv}};
        game_start     <= {2{inv}};
        game_service   <= inv;
        game_pause     <= 1'b0;     // Always active high
    end else begin
        game_joystick1 <= map_joy(joystick1);
        game_joystick2 <= map_joy(joystick2);
        game_coin      <= {joystick2[coin_bit], joystick1[coin_bit]} ^ {2{inv}};
        game_start     <= {joystick2[start_bit], joystick1[start_bit]} ^ {2{inv}};
        game_service   <= (joystick1[service_bit] | joystick2[service_bit]) ^ inv;
        game_pause     <= game_pause ^ pause_edge;
    end
end

endmodule

/* design/snd_pwm_dac.sv */
`timescale 1ns/10ps

module snd_pwm_dac import frame_pkg::*; #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic             clk_sys,
    input  logic             rst_n,
    input  logic [snd_w-1:0] snd,
    output logic             audio
);

logic [snd_w-1:0] snd_r;    // Offset binary sample
logic [snd_w-1:0] acc;
logic [snd_w:0]   acc_sum;

// Signed input moves to offset binary by flipping the sign bit
always_ff @(posedge clk_sys) begin
    snd_r <= SIGNED_SND ? {~snd[snd_w-1], snd[snd_w-2:0]} : snd;
end

assign acc_sum = {1'b0, acc} + {1'b0, snd_r};

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        acc   <= '0;
        audio <= 1'b0;
    end else begin
        acc   <= acc_sum[snd_w-1:0];
        audio <= acc_sum[snd_w];    // Carry is the pulse density
    end
end

// A silent sample never produces a pulse
a_silent: assert property (@(posedge clk_sys) disable iff (!rst_n)
    snd_r == '0 |=> !audio)
    else $error("audio pulse on zero sample");

endmodule

/* design/video_sync_in.sv */
`timescale 1ns/10ps

module video_sync_in import frame_pkg::*; (
    input  logic                                   clk_sys,
    input  logic                                   rst_n,
    input  logic                                   pxl_cen,
    input  logic [colour_in_w-1:0]                 game_r,
    input  logic [colour_in_w-1:0]                 game_g,
    input  logic [colour_in_w-1:0]                 game_b,
    input  logic                                   LHBL,
    input  logic                                   LVBL,
    input  logic                                   hs,
    input  logic                                   vs,
    output logic [num_chan-1:0][colour_in_w-1:0]   chan_colour,
    output logic                                   blank,
    output logic                                   sync_hs,
    output logic                                   sync_vs
);

// Channel order matches the loop index: R, G, B
always_ff @(posedge clk_sys) begin
    if (pxl_cen) begin
        chan_colour[0] <= game_r;
        chan_colour[1] <= game_g;
        chan_colour[2] <= game_b;
    end
end

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        blank   <= 1'b1;
        sync_hs <= 1'b0;
        sync_vs <= 1'b0;
    end else if (pxl_cen) begin
        blank   <= !(LHBL && LVBL);     // Blank lines are active low
        sync_hs <= hs;
        sync_vs <= vs;
    end
end

endmodule

/* design/colour_expand.sv */
`timescale 1ns/10ps

module colour_expand import frame_pkg::*; (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    input  logic                    blank,
    input  logic                    en_mixing,
    input  logic [colour_in_w-1:0]  colour_in,
    output logic [colour_out_w-1:0] colour_out
);

localparam int ext_w = colour_out_w - colour_in_w;

logic [colour_in_w-1:0]  prev;          // Last captured pixel
logic [colour_out_w-1:0] wide_cur;
logic [colour_out_w-1:0] wide_prev;
logic [colour_out_w:0]   mix_sum;

// Repeat the top bits so full scale maps to full scale
function automatic logic [colour_out_w-1:0] widen(input logic [colour_in_w-1:0] c);
    return {c, c[colour_in_w-1 -: ext_w]};
endfunction

// The feeder updates on the same edge, so this keeps the pixel before
always_ff @(posedge clk_sys) begin
    if (pxl_cen) begin
        prev <= colour_in;
    end
end

assign wide_cur  = widen(colour_in);
assign wide_prev = widen(prev);
assign mix_sum   = {1'b0, wide_cur} + {1'b0, wide_prev};

always_ff @(posedge clk_sys) begin
    if (!rst_n || blank) begin
        colour_out <= '0;
    end else if (en_mixing) begin
        colour_out <= mix_sum[colour_out_w:1];  // Floor of the mean
    end else begin
        colour_out <= wide_cur;
    end
end

a_blank_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
    blank |=> colour_out == '0)
    else $error("colour visible during blanking");

endmodule

/* design/vga_out.sv */
`timescale 1ns/10ps

module vga_out import frame_pkg::*; (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic [num_chan-1:0][colour_out_w-1:0] chan_out,
    input  logic                                 sync_hs,
    input  logic                                 sync_vs,
    output logic [colour_out_w-1:0]              VGA_R,
    output logic [colour_out_w-1:0]              VGA_G,
    output logic [colour_out_w-1:0]              VGA_B,
    output logic                                 VGA_HS,
    output logic                                 VGA_VS
);

logic hs_d;     // Matches the colour_expand stage
logic vs_d;

always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
        hs_d   <= 1'b0;
        vs_d   <= 1'b0;
        VGA_HS <= 1'b0;
        VGA_VS <= 1'b0;
        VGA_R  <= '0;
        VGA_G  <= '0;
        VGA_B  <= '0;
    end else begin
        hs_d   <= sync_hs;
        vs_d   <= sync_vs;
        VGA_HS <= hs_d;
        VGA_VS <= vs_d;
        VGA_R  <= chan_out[0];
        VGA_G  <= chan_out[1];
        VGA_B  <= chan_out[2];
    end
end

endmodule

/* design/mist_frame_top.sv */
`timescale 1ns/10ps

module mist_frame_top import frame_pkg::*; #(
    parameter bit SIGNED_SND              = 1'b0,
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
) (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    // Reset causes
    input  logic                    downloading,
    input  logic                    dip_flip,
    input  logic                    rst_req,
    output logic                    rst,
    output logic                    game_rst,
    // Controls
    input  logic [ctrl_w-1:0]       joystick1,
    input  logic [ctrl_w-1:0]       joystick2,
    output logic [joy_w-1:0]        game_joystick1,
    output logic [joy_w-1:0]        game_joystick2,
    output logic [1:0]              game_coin,
    output logic [1:0]              game_start,
    output logic                    game_service,
    output logic                    game_pause,
    // Sound
    input  logic [snd_w-1:0]        snd,
    output logic                    AUDIO_L,
    output logic                    AUDIO_R,
    // Video
    input  logic                    en_mixing,
    input  logic [colour_in_w-1:0]  game_r,
    input  logic [colour_in_w-1:0]  game_g,
    input  logic [colour_in_w-1:0]  game_b,
    input  logic                    LHBL,
    input  logic                    LVBL,
    input  logic                    hs,
    input  logic                    vs,
    output logic [colour_out_w-1:0] VGA_R,
    output logic [colour_out_w-1:0] VGA_G,
    output logic [colour_out_w-1:0] VGA_B,
    output logic                    VGA_HS,
    output logic                    VGA_VS
);

logic [num_chan-1:0][colour_in_w-1:0]  chan_colour;
logic [num_chan-1:0][colour_out_w-1:0] chan_out;
logic                                  blank;
logic                                  sync_hs;
logic                                  sync_vs;

assign AUDIO_R = AUDIO_L;   // Mono game sound on both sides

board_reset u_reset (
    .clk_sys     ( clk_sys     ),
    .rst_n       ( rst_n       ),
    .downloading ( downloading ),
    .dip_flip    ( dip_flip    ),
    .rst_req     ( rst_req     ),
    .rst         ( rst         ),
    .game_rst    ( game_rst    )
);

joystick_map #(
    .THREE_BUTTONS           ( THREE_BUTTONS           ),
    .GAME_INPUTS_ACTIVE_HIGH ( GAME_INPUTS_ACTIVE_HIGH )
) u_joy (
    .clk_sys        ( clk_sys        ),
    .rst_n          ( rst_n          ),
    .game_rst       ( game_rst       ),
    .joystick1      ( joystick1      ),
    .joystick2      ( joystick2      ),
    .game_joystick1 ( game_joystick1 ),
    .game_joystick2 ( game_joystick2 ),
    .game_coin      ( game_coin      ),
    .game_start     ( game_start     ),
    .game_service   ( game_service   ),
    .game_pause     ( game_pause     )
);

snd_pwm_dac #(.SIGNED_SND(SIGNED_SND)) u_dac (
    .clk_sys ( clk_sys ),
    .rst_n   ( rst_n   ),
    .snd     ( snd     ),
    .audio   ( AUDIO_L )
);

video_sync_in u_sync (
    .clk_sys     ( clk_sys     ),
    .rst_n       ( rst_n       ),
    .pxl_cen     ( pxl_cen     ),
    .game_r      ( game_r      ),
    .game_g      ( game_g      ),
    .game_b      ( game_b      ),
    .LHBL        ( LHBL        ),
    .LVBL        ( LVBL        ),
    .hs          ( hs          ),
    .vs          ( vs          ),
    .chan_colour ( chan_colour ),
    .blank       ( blank       ),
    .sync_hs     ( sync_hs     ),
    .sync_vs     ( sync_vs     )
);

// One widening stage per colour channel
for (genvar i = 0; i < num_chan; i++) begin : g_chan
    colour_expand u_exp (
        .clk_sys    ( clk_sys        ),
        .rst_n      ( rst_n          ),
        .pxl_cen    ( pxl_cen        ),
        .blank      ( blank          ),
        .en_mixing  ( en_mixing      ),
        .colour_in  ( chan_colour[i] ),
        .colour_out ( chan_out[i]    )
    );
end

vga_out u_vga (
    .clk_sys  ( clk_sys  ),
    .rst_n    ( rst_n    ),
    .chan_out ( chan_out ),
    .sync_hs  ( sync_hs  ),
    .sync_vs  ( sync_vs  ),
    .VGA_R    ( VGA_R    ),
    .VGA_G    ( VGA_G    ),
    .VGA_B    ( VGA_B    ),
    .VGA_HS   ( VGA_HS   ),
    .VGA_VS   ( VGA_VS   )
);

endmodule

/* sim/tb_mist_frame.sv */
`timescale 1ns/10ps

module tb_mist_frame import frame_pkg::*; ();

localparam bit SIGNED_SND              = 1'b0;
localparam bit THREE_BUTTONS           = 1'b0;
localparam bit GAME_INPUTS_ACTIVE_HIGH = 1'b0;

// Phase lengths in clk_sys cycles
localparam int reset_cycles = 10;
localparam int settle_cycles = 30;
localparam int dl_cycles = 8;
localparam int joy_cycles = 100;
localparam int audio_settle = 4;
localparam int audio_window = 4096;
localparam int video_cycles = 400;
localparam int run_cycles = reset_cycles + 4 * settle_cycles + 1 + dl_cycles + joy_cycles
                          + 3 * (audio_settle + audio_window + 1) + 2 * video_cycles + 2;
localparam longint timeout_ns = longint'(run_cycles + 500) * 20;

localparam int area_reset = 0;
localparam int area_joy   = 1;
localparam int area_audio = 2;
localparam int area_video = 3;

// One entry per clk_sys edge with the newest at index 0
typedef struct packed {
    logic [colour_in_w-1:0] r, g, b;       // Latest captured pixel
    logic [colour_in_w-1:0] pr, pg, pb;    // The capture before it
    logic                   blank, hs, vs;
    logic                   mix;           // en_mixing seen at this edge
} pixel_t;

logic clk_sys, rst_n, pxl_cen, downloading, dip_flip, rst_req;
logic [ctrl_w-1:0] joystick1, joystick2;
logic [snd_w-1:0] snd;
logic en_mixing, LHBL, LVBL, hs, vs;
logic [colour_in_w-1:0] game_r, game_g, game_b;
logic rst, game_rst, game_service, game_pause, AUDIO_L, AUDIO_R, VGA_HS, VGA_VS;
logic [joy_w-1:0] game_joystick1, game_joystick2;
logic [1:0] game_coin, game_start;
logic [colour_out_w-1:0] VGA_R, VGA_G, VGA_B;

logic [31:0] lfsr = 32'd95119;
localparam logic [31:0] lfsr_taps = 32'h8020_0003;
int err_count [4];
bit video_run;
bit model_live;
bit vid_ok;
bit audio_ready;
longint audio_ones, audio_target;

// Model state updated on the rising edge
bit exp_rst, exp_game_rst, exp_service, exp_pause, exp_hs, exp_vs;
logic [joy_w-1:0] exp_joy1, exp_joy2;
logic [1:0] exp_coin, exp_start;
logic [colour_out_w-1:0] exp_r, exp_g, exp_b;
int rst_age, hold, live_edges;
bit dl_prev, dip_prev;
logic [1:0] pause_prev;
pixel_t cap;
pixel_t hist[$];

mist_frame_top #(
    .SIGNED_SND              ( SIGNED_SND              ),
    .THREE_BUTTONS           ( THREE_BUTTONS           ),
    .GAME_INPUTS_ACTIVE_HIGH ( GAME_INPUTS_ACTIVE_HIGH )
) i_mist_frame_top (.*);

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
        val  = {val[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
    end
    return val;
endfunction

function automatic logic [colour_out_w-1:0] to_vga_level(input logic [colour_in_w-1:0] c);
    return {c, c[3:2]};     // Top bits repeated below
endfunction

function automatic logic [colour_out_w-1:0] chan_level(input logic [colour_in_w-1:0] cur,
        input logic [colour_in_w-1:0] prev, input logic blank, input logic mix);
    logic [colour_out_w:0] sum;
    sum = {1'b0, to_vga_level(cur)} + {1'b0, to_vga_level(prev)};
    if (blank) return '0;
    return mix ? sum[colour_out_w:1] : to_vga_level(cur);
endfunction

// Game side level of one pressed controller bit
function automatic logic game_level(input logic pressed);
    return GAME_INPUTS_ACTIVE_HIGH ? pressed : !pressed;
endfunction

// Masked game bits in the polarity the game expects
function automatic logic [joy_w-1:0] game_bits(input logic [ctrl_w-1:0] word);
    logic [joy_w-1:0] pressed;
    pressed = word[joy_w-1:0];
    if (THREE_BUTTONS) pressed[9:7] = 3'b000;
    return GAME_INPUTS_ACTIVE_HIGH ? pressed : ~pressed;
endfunction

task automatic log_mismatch(input int area, input string msg);
    err_count[area]++;
    $display("** Error at %0t: %s", $time, msg);
endtask

initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
end

initial begin
    #(timeout_ns);
    $display("Timeout: the run did not reach its end within %0d ns", timeout_ns);
    $display("CHECKS FAILED");
    $finish;
end

// Reference model from the input history
always @(posedge clk_sys) begin : model
    bit inact;
    inact = !GAME_INPUTS_ACTIVE_HIGH;
    if (!rst_n || exp_game_rst) begin
        exp_joy1    = {joy_w{inact}};
        exp_joy2    = {joy_w{inact}};
        exp_coin    = {2{inact}};
        exp_start   = {2{inact}};
        exp_service = inact;
        exp_pause   = 1'b0;
    end else begin
        exp_joy1    = game_bits(joystick1);
        exp_joy2    = game_bits(joystick2);
        exp_coin    = {game_level(joystick2[coin_bit]), game_level(joystick1[coin_bit])};
        exp_start   = {game_level(joystick2[start_bit]), game_level(joystick1[start_bit])};
        exp_service = game_level(joystick1[service_bit] || joystick2[service_bit]);
        if ((joystick1[pause_bit] && !pause_prev[0]) || (joystick2[pause_bit] && !pause_prev[1]))
            exp_pause = !exp_pause;
    end
    pause_prev = {joystick2[pause_bit], joystick1[pause_bit]};

    if (!rst_n) begin
        rst_age      = 0;
        hold         = 0;
        exp_rst      = 1'b1;
        exp_game_rst = 1'b1;
    end else begin
        if (rst_age <= rst_stretch) rst_age++;
        exp_rst = rst_age <= rst_stretch;
        if (dip_flip != dip_prev || rst_req || (dl_prev && !downloading)) hold = rst_stretch;
        exp_game_rst = exp_rst || downloading || hold != 0;
        if (hold != 0) hold--;
    end
    dl_prev  = downloading;
    dip_prev = dip_flip;

    if (pxl_cen) begin
        {cap.pr, cap.pg, cap.pb} = {cap.r, cap.g, cap.b};
        {cap.r, cap.g, cap.b}    = {game_r, game_g, game_b};
    end
    if (!rst_n) begin
        {cap.blank, cap.hs, cap.vs} = 3'b100;
    end else if (pxl_cen) begin
        cap.blank = !(LHBL && LVBL);
        {cap.hs, cap.vs} = {hs, vs};
    end
    cap.mix = en_mixing;
    hist.push_front(cap);
    if (hist.size() > 3) void'(hist.pop_back());
    live_edges = !rst_n ? 0 : (live_edges < 3 ? live_edges + 1 : 3);
    vid_ok = live_edges >= 3 && hist.size() == 3;
    if (vid_ok) begin   // Capture from two edges back reaches VGA now
        exp_r  = chan_level(hist[2].r, hist[2].pr, hist[2].blank, hist[1].mix);
        exp_g  = chan_level(hist[2].g, hist[2].pg, hist[2].blank, hist[1].mix);
        exp_b  = chan_level(hist[2].b, hist[2].pb, hist[2].blank, hist[1].mix);
        exp_hs = hist[2].hs;
        exp_vs = hist[2].vs;
    end
    model_live = 1'b1;
end

// Outputs are stable by the falling edge
a_rst: assert property (@(negedge clk_sys) model_live |-> rst == exp_rst)
    else log_mismatch(area_reset, "rst differs from the reset rule");
a_game_rst: assert property (@(negedge clk_sys) model_live |-> game_rst == exp_game_rst)
    else log_mismatch(area_reset, "game_rst differs from the reset rule");
a_joy: assert property (@(negedge clk_sys) model_live |->
        game_joystick1 == exp_joy1 && game_joystick2 == exp_joy2)
    else log_mismatch(area_joy, "game joystick bits wrong");
a_coin_start: assert property (@(negedge clk_sys) model_live |->
        game_coin == exp_coin && game_start == exp_start && game_service == exp_service)
    else log_mismatch(area_joy, "coin, start or service wrong");
a_pause: assert property (@(negedge clk_sys) model_live |-> game_pause == exp_pause)
    else log_mismatch(area_joy, "game_pause wrong");
a_audio_r: assert property (@(negedge clk_sys) AUDIO_R == AUDIO_L)
    else log_mismatch(area_audio, "AUDIO_R differs from AUDIO_L");
a_density: assert property (@(posedge clk_sys) audio_ready |->
        audio_ones * 65536 + 65536 >= audio_target && audio_ones * 65536 <= audio_target + 65536)
    else log_mismatch(area_audio, "pulse count off by more than one");
a_colour: assert property (@(negedge clk_sys) vid_ok |->
        VGA_R == exp_r && VGA_G == exp_g && VGA_B == exp_b)
    else log_mismatch(area_video, "VGA colour wrong");
a_sync: assert property (@(negedge clk_sys) vid_ok |-> VGA_HS == exp_hs && VGA_VS == exp_vs)
    else log_mismatch(area_video, "VGA sync not aligned");

// One cycle of random controls and video while that phase runs
task automatic step();
    @(negedge clk_sys);
    joystick1 = 16'(take_bits(16));
    joystick2 = 16'(take_bits(16));
    if (video_run) begin
        pxl_cen = !pxl_cen;     // Every other cycle
        game_r  = 4'(take_bits(4));
        game_g  = 4'(take_bits(4));
        game_b  = 4'(take_bits(4));
        LHBL    = take_bits(2) != 0;    // Mostly visible
        LVBL    = take_bits(3) != 0;
        hs      = 1'(take_bits(1));
        vs      = 1'(take_bits(1));
    end
endtask

task automatic measure_audio(input logic [snd_w-1:0] v);
    longint ones;
    longint level;
    ones  = 0;
    snd   = v;
    level = SIGNED_SND ? longint'(v ^ 16'h8000) : longint'(v);
    repeat (audio_settle) step();
    repeat (audio_window) begin
        step();
        if (AUDIO_L) ones++;
    end
    audio_ones   = ones;
    audio_target = level * audio_window;
    audio_ready  = 1'b1;
    step();
    audio_ready  = 1'b0;
endtask

initial begin
    {rst_n, pxl_cen, downloading, dip_flip, rst_req} = '0;
    {joystick1, joystick2, snd} = '0;
    {game_r, game_g, game_b} = '0;
    {en_mixing, hs, vs} = '0;
    {LHBL, LVBL} = 2'b11;
    {audio_ready, audio_ones, audio_target} = '0;
    video_run = 1'b0;

    repeat (reset_cycles) step();
    rst_n = 1'b1;
    repeat (settle_cycles) step();
    dip_flip = 1'b1;
    repeat (settle_cycles) step();
    rst_req = 1'b1;
    step();
    rst_req = 1'b0;
    repeat (settle_cycles) step();
    downloading = 1'b1;     // ROM load
    repeat (dl_cycles) step();
    downloading = 1'b0;
    repeat (settle_cycles) step();
    repeat (joy_cycles) step();

    measure_audio(16'h0000);
    measure_audio(16'h4000);
    measure_audio(16'hC000);

    video_run = 1'b1;
    repeat (video_cycles) step();
    en_mixing = 1'b1;
    repeat (video_cycles) step();
    video_run = 1'b0;
    step();
    step();

    $display("Error counts: reset %0d, joystick %0d, audio %0d, video %0d",
             err_count[area_reset], err_count[area_joy], err_count[area_audio],
             err_count[area_video]);
    if (err_count.sum() == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
end

endmodule

/* flist.f */
design/frame_pkg.sv
design/board_reset.sv
design/joystick_map.sv
design/snd_pwm_dac.sv
design/video_sync_in.sv
design/colour_expand.sv
design/vga_out.sv
design/mist_frame_top.sv
sim/tb_mist_frame.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_mist_frame -o tb_mist_frame > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/tb_mist_frame > "$SIM_LOG" 2>&1 \
    || { echo "Build or simulation error, see $BUILD_LOG and $SIM_LOG"; exit 1; }

grep -q "CHECKS FAILED" "$SIM_LOG" \
    && { echo "Simulation failed, see $SIM_LOG"; exit 1; } \
    || echo "Simulation passed"
